// File: list.f
rtl/am_lock_pkg.sv
rtl/am_comparator.sv
rtl/am_lock_fsm.sv
rtl/bip_calculator.sv
rtl/am_error_counter.sv
rtl/am_lock_module.sv
tests/tb_clock_gen.sv
tests/am_lock_tb.sv

// File: rtl/am_comparator.sv
/*
  masked marker comparator
  matches the block's marker fields against every lane entry
*/

`timescale 1ns/1ns

module am_comparator
	import am_lock_pkg::*;
(
	input  logic [NB_AM-1:0]      i_am_value,       // marker fields of current block
	input  logic [NB_AM-1:0]      i_compare_mask,   // one = bit is compared
	input  logic                  i_enable_mask,    // restrict to locked lane
	input  logic [NB_LANE_ID-1:0] i_lane_sel,       // locked lane from fsm
	output am_match_t             o_match
);

	logic [N_ALIGNER-1:0] hit;     // raw per-lane match
	logic [N_ALIGNER-1:0] allow;   // lanes permitted to report

	always_comb
	begin
		hit   = '0;
		allow = '1;
		for (int i = 0; i < N_ALIGNER; i++)
		begin
			// differences outside the mask are ignored
			hit[i] = ~|((i_am_value ^ AM_TABLE[i]) & i_compare_mask);
			if (i_enable_mask && (i_lane_sel != NB_LANE_ID'(i)))
			begin
				allow[i] = 1'b0;   // only the captured lane counts
			end
		end
	end

	always_comb
	begin
		o_match.vector = hit & allow;
		o_match.any    = |(hit & allow);
	end

endmodule

// File: rtl/am_error_counter.sv
/*
  BIP3 error counter
  saturating count of mismatches at checked markers
*/

`timescale 1ns/1ns

module am_error_counter
	import am_lock_pkg::*;
(
	input  logic                        i_clock,
	input  logic                        i_reset,
	input  logic                        i_enable,
	input  logic                        i_valid,
	input  am_event_t                   i_event,
	input  logic [NB_BIP-1:0]           i_received_bip,     // bip3 field of marker
	input  logic [NB_BIP-1:0]           i_calculated_bip,   // from accumulator
	output logic [NB_ERROR_COUNTER-1:0] o_error_count
);

	logic bip_error;

	assign bip_error = i_event.check && (i_received_bip != i_calculated_bip);

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			o_error_count <= '0;
		end
		else if (i_enable && i_valid && bip_error && (o_error_count != '1))
		begin
			o_error_count <= o_error_count + 1'b1;   // holds at max
		end
	end

endmodule

// File: rtl/am_lock_fsm.sv
/*
  marker lock FSM
  search, acquire and locked states, marker period counter,
  good and bad marker counts, lane capture and marker events
*/

`timescale 1ns/1ns

module am_lock_fsm
	import am_lock_pkg::*;
(
	input  logic                  i_clock,
	input  logic                  i_reset,
	input  logic                  i_enable,       // register file enable
	input  logic                  i_valid,        // one block strobe
	input  logic                  i_block_lock,   // level from block sync
	input  am_match_t             i_match,        // from comparator, same cycle
	input  logic [NB_VAL_AM-1:0]  i_lock_thr,     // good markers needed for lock
	input  logic [NB_INV_AM-1:0]  i_unlock_thr,   // bad markers that drop lock
	output logic                  o_enable_mask,
	output logic [NB_LANE_ID-1:0] o_lane_sel,
	output am_event_t             o_event,
	output logic                  o_am_lock,
	output logic                  o_resync
);

	am_state_e              state;
	logic [NB_BLOCK_CNT-1:0] block_cnt;   // valid blocks since last marker
	logic [NB_VAL_AM-1:0]    good_cnt;
	logic [NB_INV_AM-1:0]    bad_cnt;
	logic [NB_LANE_ID-1:0]   lane_id;     // captured at first marker
	logic                    active;      // enabled and block sync locked
	logic                    blk;         // block accepted this cycle
	logic                    expected;    // counter says marker is due
	logic [NB_VAL_AM-1:0]    good_inc;
	logic [NB_INV_AM-1:0]    bad_inc;
	logic [NB_VAL_AM-1:0]    lock_thr;
	logic [NB_INV_AM-1:0]    unlock_thr;
	logic [NB_LANE_ID-1:0]   found_lane;

	// lowest matching lane wins
	function automatic logic [NB_LANE_ID-1:0] lowest_lane(input logic [N_ALIGNER-1:0] vec);
		logic [NB_LANE_ID-1:0] id;
		id = '0;
		for (int i = N_ALIGNER-1; i >= 0; i--)
		begin
			if (vec[i])
			begin
				id = NB_LANE_ID'(i);
			end
		end
		return id;
	endfunction

	assign active     = i_enable && i_block_lock;
	assign blk        = active && i_valid;
	assign expected   = (state != ST_SEARCH) && (block_cnt == NB_BLOCK_CNT'(AM_PERIOD-1));
	assign found_lane = lowest_lane(i_match.vector);
	assign good_inc   = (good_cnt == '1) ? good_cnt : good_cnt + 1'b1;   // saturate
	assign bad_inc    = (bad_cnt == '1) ? bad_cnt : bad_cnt + 1'b1;
	assign lock_thr   = (i_lock_thr == '0) ? NB_VAL_AM'(1) : i_lock_thr;  // zero acts as one
	assign unlock_thr = (i_unlock_thr == '0) ? NB_INV_AM'(1) : i_unlock_thr;

	assign o_enable_mask = (state != ST_SEARCH);   // compare only the captured lane
	assign o_lane_sel    = lane_id;

	always_comb
	begin
		o_event = '0;
		if (blk)
		begin
			if (state == ST_SEARCH)
			begin
				o_event.at_marker = i_match.any;   // first marker, not checked
				o_event.lane_id   = found_lane;
			end
			else
			begin
				o_event.at_marker = expected;
				o_event.check     = expected && i_match.any;
				o_event.lane_id   = lane_id;
			end
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state     <= ST_SEARCH;
			block_cnt <= '0;
			good_cnt  <= '0;
			bad_cnt   <= '0;
			lane_id   <= '0;
			o_am_lock <= 1'b0;
			o_resync  <= 1'b0;
		end
		else if (!active)
		begin
			state     <= ST_SEARCH;   // back to search, no resync
			block_cnt <= '0;
			good_cnt  <= '0;
			bad_cnt   <= '0;
			o_am_lock <= 1'b0;
			o_resync  <= 1'b0;
		end
		else
		begin
			o_resync <= 1'b0;   // single cycle pulse
			if (i_valid)
			begin
				case (state)
					ST_SEARCH:
					begin
						if (i_match.any)
						begin
							lane_id   <= found_lane;
							block_cnt <= '0;
							good_cnt  <= NB_VAL_AM'(1);
							bad_cnt   <= '0;
							state     <= ST_ACQUIRE;
						end
					end
					ST_ACQUIRE:
					begin
						if (!expected)
						begin
							block_cnt <= block_cnt + 1'b1;
						end
						else if (i_match.any)
						begin
							block_cnt <= '0;
							good_cnt  <= good_inc;
							bad_cnt   <= '0;
							if (good_inc >= lock_thr)
							begin
								state     <= ST_LOCKED;
								o_am_lock <= 1'b1;
							end
						end
						else
						begin
							state     <= ST_SEARCH;   // acquisition failed
							block_cnt <= '0;
							good_cnt  <= '0;
							o_resync  <= 1'b1;
						end
					end
					ST_LOCKED:
					begin
						if (!expected)
						begin
							block_cnt <= block_cnt + 1'b1;
						end
						else if (i_match.any)
						begin
							block_cnt <= '0;
							good_cnt  <= good_inc;
							bad_cnt   <= '0;
						end
						else if (bad_inc >= unlock_thr)
						begin
							state     <= ST_SEARCH;   // lock lost
							block_cnt <= '0;
							good_cnt  <= '0;
							bad_cnt   <= '0;
							o_am_lock <= 1'b0;
							o_resync  <= 1'b1;
						end
						else
						begin
							block_cnt <= '0;   // keep period on a bad marker
							bad_cnt   <= bad_inc;
						end
					end
					default:
					begin
						state <= ST_SEARCH;
					end
				endcase
			end
		end
	end

endmodule

// File: rtl/am_lock_module.sv
/*
  alignment marker lock stage, one receive lane
  input split, comparator, lock FSM, BIP3 check,
  idle substitution at checked markers, registered outputs
*/

`timescale 1ns/1ns

module am_lock_module
	import am_lock_pkg::*;
(
	input  logic                        i_clock,
	input  logic                        i_reset,
	input  logic                        i_rf_enable,
	input  logic                        i_valid,               // one block strobe
	input  logic                        i_block_lock,          // level from block sync
	input  logic [NB_CODED_BLOCK-1:0]   i_data,
	input  logic [NB_VAL_AM-1:0]        i_rf_valid_am_thr,
	input  logic [NB_INV_AM-1:0]        i_rf_invalid_am_thr,
	input  logic [NB_AM-1:0]            i_rf_compare_mask,
	output logic [NB_CODED_BLOCK-1:0]   o_data,
	output logic                        o_valid,
	output logic [NB_LANE_ID-1:0]       o_lane_id,
	output logic [NB_ERROR_COUNTER-1:0] o_error_counter,
	output logic                        o_am_lock,
	output logic                        o_resync,
	output logic                        o_start_of_lane
);

	am_block_t             in_block;
	logic [NB_AM-1:0]      am_value;
	logic [NB_BIP-1:0]     received_bip;
	logic [NB_BIP-1:0]     calculated_bip;
	am_match_t             match;
	am_event_t             am_event;
	logic                  enable_mask;
	logic [NB_LANE_ID-1:0] lane_sel;
	logic                  accepted;      // block taken this cycle

	assign in_block     = i_data;
	assign am_value     = {in_block.payload[63:40], in_block.payload[31:8]};   // skip bip3 and bip7
	assign received_bip = in_block.payload[39:32];
	assign accepted     = i_valid && i_rf_enable;

	am_comparator u_am_comparator (
		.i_am_value     (am_value),
		.i_compare_mask (i_rf_compare_mask),
		.i_enable_mask  (enable_mask),
		.i_lane_sel     (lane_sel),
		.o_match        (match)
	);

	am_lock_fsm u_am_lock_fsm (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_enable      (i_rf_enable),
		.i_valid       (i_valid),
		.i_block_lock  (i_block_lock),
		.i_match       (match),
		.i_lock_thr    (i_rf_valid_am_thr),
		.i_unlock_thr  (i_rf_invalid_am_thr),
		.o_enable_mask (enable_mask),
		.o_lane_sel    (lane_sel),
		.o_event       (am_event),
		.o_am_lock     (o_am_lock),
		.o_resync      (o_resync)
	);

	bip_calculator u_bip_calculator (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_valid (accepted),
		.i_block (in_block),
		.i_event (am_event),
		.o_bip3  (calculated_bip)
	);

	am_error_counter u_am_error_counter (
		.i_clock          (i_clock),
		.i_reset          (i_reset),
		.i_enable         (i_rf_enable),
		.i_valid          (i_valid),
		.i_event          (am_event),
		.i_received_bip   (received_bip),
		.i_calculated_bip (calculated_bip),
		.o_error_count    (o_error_counter)
	);

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			o_data          <= '0;
			o_valid         <= 1'b0;
			o_start_of_lane <= 1'b0;
			o_lane_id       <= '0;
		end
		else
		begin
			o_valid         <= accepted;
			o_start_of_lane <= accepted && am_event.check;
			if (accepted)
			begin
				if (am_event.check)
				begin
					o_data    <= {CTRL_SH, BLOCK_TYPE_CTRL, 56'd0};   // idle replaces marker
					o_lane_id <= am_event.lane_id;
				end
				else
				begin
					o_data <= in_block;
				end
			end
		end
	end

endmodule

// File: rtl/am_lock_pkg.sv
/*
  shared sizes and constants for the marker lock stage
  lane marker table, coded block and match/event structs
  lock FSM state enum
*/

package am_lock_pkg;

	localparam int NB_CODED_BLOCK   = 66;   // sync header plus payload
	localparam int NB_AM            = 48;   // M0..M2 and M4..M6
	localparam int N_ALIGNER        = 4;    // lanes in the table
	localparam int NB_LANE_ID       = 2;
	localparam int AM_PERIOD        = 32;   // valid blocks, marker included
	localparam int NB_BLOCK_CNT     = 5;
	localparam int NB_BIP           = 8;
	localparam int NB_ERROR_COUNTER = 16;
	localparam int NB_VAL_AM        = 3;
	localparam int NB_INV_AM        = 3;

	localparam logic [1:0] CTRL_SH         = 2'b10;
	localparam logic [7:0] BLOCK_TYPE_CTRL = 8'h1E;

	// M0 M1 M2 followed by their inverse M4 M5 M6
	localparam logic [NB_AM-1:0] AM_TABLE [N_ALIGNER] = '{
		48'hC16821_3E97DE,   // lane 0
		48'h9D718E_628E71,   // lane 1
		48'h594BE8_A6B417,   // lane 2
		48'h4D957B_B26A84    // lane 3
	};

	typedef struct packed {
		logic [1:0]  sh;        // sync header
		logic [63:0] payload;
	} am_block_t;

	typedef struct packed {
		logic [N_ALIGNER-1:0] vector;   // one bit per lane
		logic                 any;      // or of vector
	} am_match_t;

	typedef struct packed {
		logic                  at_marker;   // block sits at a marker position
		logic                  check;       // expected marker that matched
		logic [NB_LANE_ID-1:0] lane_id;
	} am_event_t;

	typedef enum logic [1:0] {
		ST_SEARCH,
		ST_ACQUIRE,
		ST_LOCKED
	} am_state_e;

endpackage

// File: rtl/bip_calculator.sv
/*
  BIP3 accumulator
  interleaved parity over the payloads between two markers
*/

`timescale 1ns/1ns

module bip_calculator
	import am_lock_pkg::*;
(
	input  logic              i_clock,
	input  logic              i_reset,
	input  logic              i_valid,    // accepted block strobe
	input  am_block_t         i_block,
	input  am_event_t         i_event,    // at_marker clears the sum
	output logic [NB_BIP-1:0] o_bip3
);

	logic [NB_BIP-1:0] fold;   // parity of this payload
	logic [NB_BIP-1:0] acc;    // parity since previous marker

	// bit j collects payload bits with index mod 8 equal to j
	always_comb
	begin
		fold = '0;
		for (int k = 0; k < 64/NB_BIP; k++)
		begin
			fold = fold ^ i_block.payload[k*NB_BIP +: NB_BIP];
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			acc <= '0;
		end
		else if (i_valid)
		begin
			if (i_event.at_marker)
			begin
				acc <= '0;   // marker itself is excluded
			end
			else
			begin
				acc <= acc ^ fold;
			end
		end
	end

	assign o_bip3 = acc;   // value seen by the marker block

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with verilator and run it, exit status carries the result
verilator --binary --top-module am_lock_tb -f list.f -o am_lock_sim \
	&& ./obj_dir/am_lock_sim \
	|| exit 1

// File: tests/am_lock_tb.sv
/*
  table-driven testbench for the marker lock stage
  stimulus builder with random payloads and fault injection,
  reference model of lock, BIP3 and error rules, output checks, watchdog
*/

`timescale 1ns/1ns

module am_lock_tb
	import am_lock_pkg::*;
();

	typedef enum logic [1:0] {
		F_GOOD,
		F_BAD_MK,      // compared marker bit flipped
		F_BAD_BIP,     // received bip3 corrupted
		F_MASK_FLIP    // marker bits flipped under mask zeros
	} fault_e;

	typedef struct packed {
		logic [1:0]  lane;
		logic [2:0]  val_thr;
		logic [2:0]  inv_thr;
		logic [47:0] mask;
		logic [3:0]  periods;
		fault_e      fault;         // applied to a run of periods
		logic [3:0]  first_fault;
		logic [3:0]  n_fault;
		logic        exp_lock;
		logic [1:0]  exp_lane;
		logic [15:0] exp_err;       // errors added by this entry
		logic [1:0]  exp_resync;    // resync pulses in this entry
	} test_t;

	logic        clock;
	logic        reset;
	logic        rf_enable;
	logic        valid;
	logic        block_lock;
	logic [65:0] data;
	logic [2:0]  valid_thr;
	logic [2:0]  invalid_thr;
	logic [47:0] compare_mask;
	logic [65:0] o_data;
	logic        o_valid;
	logic [1:0]  o_lane_id;
	logic [15:0] o_error_counter;
	logic        o_am_lock;
	logic        o_resync;
	logic        o_start_of_lane;

	test_t       tests [9];
	string       names [9];
	int          n_tests;
	string       cur_name;
	int          resync_seen;

	am_state_e   m_state;   // model of lock state
	int          m_cnt;
	int          m_good;
	int          m_bad;
	logic [1:0]  m_lane;
	logic [7:0]  m_acc;     // bip3 since last marker position
	logic [65:0] exp_data;
	logic        exp_valid;
	logic        exp_sol;
	logic        exp_resync;
	logic        exp_lock;
	logic [1:0]  exp_lane;
	logic [15:0] exp_err;

	tb_clock_gen u_clock_gen (
		.o_clock (clock),
		.o_reset (reset)
	);

	am_lock_module UUT (
		.i_clock             (clock),
		.i_reset             (reset),
		.i_rf_enable         (rf_enable),
		.i_valid             (valid),
		.i_block_lock        (block_lock),
		.i_data              (data),
		.i_rf_valid_am_thr   (valid_thr),
		.i_rf_invalid_am_thr (invalid_thr),
		.i_rf_compare_mask   (compare_mask),
		.o_data              (o_data),
		.o_valid             (o_valid),
		.o_lane_id           (o_lane_id),
		.o_error_counter     (o_error_counter),
		.o_am_lock           (o_am_lock),
		.o_resync            (o_resync),
		.o_start_of_lane     (o_start_of_lane)
	);

	task automatic report_failure(input string why);
		$display("SOME TESTS FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check_value(input string what, input logic [65:0] expected,
		input logic [65:0] actual);
		if (expected !== actual)
		begin
			$display("FAILED %s %s: expected %h, actual %h", cur_name, what, expected, actual);
			report_failure("output mismatch");
		end
	endtask

	function automatic void add_test(input string name, input int lane, input int vthr,
		input int ithr, input logic [47:0] mask, input int periods, input fault_e fault,
		input int first, input int count, input int lock, input int lane_id, input int err,
		input int resync);
		names[n_tests]             = name;
		tests[n_tests].lane        = 2'(lane);
		tests[n_tests].val_thr     = 3'(vthr);
		tests[n_tests].inv_thr     = 3'(ithr);
		tests[n_tests].mask        = mask;
		tests[n_tests].periods     = 4'(periods);
		tests[n_tests].fault       = fault;
		tests[n_tests].first_fault = 4'(first);
		tests[n_tests].n_fault     = 4'(count);
		tests[n_tests].exp_lock    = 1'(lock);
		tests[n_tests].exp_lane    = 2'(lane_id);
		tests[n_tests].exp_err     = 16'(err);
		tests[n_tests].exp_resync  = 2'(resync);
		n_tests++;
	endfunction

	// bit j is the parity of payload bits with index mod 8 equal to j
	function automatic logic [7:0] interleaved_parity(input logic [63:0] p);
		logic [7:0] f;
		f = 8'h00;
		for (int i = 0; i < 64; i++)
		begin
			f[i % 8] ^= p[i];
		end
		return f;
	endfunction

	task automatic check_outputs();
		check_value("o_valid", 66'(exp_valid), 66'(o_valid));
		check_value("o_data", exp_data, o_data);
		check_value("o_start_of_lane", 66'(exp_sol), 66'(o_start_of_lane));
		check_value("o_resync", 66'(exp_resync), 66'(o_resync));
		check_value("o_am_lock", 66'(exp_lock), 66'(o_am_lock));
		check_value("o_lane_id", 66'(exp_lane), 66'(o_lane_id));
		check_value("o_error_counter", 66'(exp_err), 66'(o_error_counter));
	endtask

	// outputs expected after the edge that samples this cycle's inputs
	task automatic predict(input logic v, input logic en, input logic [65:0] blk);
		logic [63:0] p;
		logic [47:0] am;
		logic [3:0]  hit;
		logic        at;
		logic        chk;
		int          thr_lock;
		int          thr_unlock;
		p          = blk[63:0];
		am         = {p[63:40], p[31:8]};
		at         = 1'b0;
		chk        = 1'b0;
		thr_lock   = (valid_thr == '0) ? 1 : int'(valid_thr);
		thr_unlock = (invalid_thr == '0) ? 1 : int'(invalid_thr);
		for (int i = 0; i < 4; i++)
		begin
			hit[i] = (((am ^ AM_TABLE[i]) & compare_mask) == '0);
		end
		exp_valid  = v && en;
		exp_sol    = 1'b0;
		exp_resync = 1'b0;
		if (!en)
		begin
			m_state  = ST_SEARCH;   // disabled drops lock quietly
			m_cnt    = 0;
			m_good   = 0;
			m_bad    = 0;
			exp_lock = 1'b0;
		end
		else if (v)
		begin
			if (m_state == ST_SEARCH)
			begin
				for (int i = 3; i >= 0; i--)
				begin
					if (hit[i])
					begin
						at     = 1'b1;
						m_lane = 2'(i);   // lowest lane ends up here
					end
				end
				if (at)
				begin
					m_cnt   = 0;
					m_good  = 1;
					m_bad   = 0;
					m_state = ST_ACQUIRE;
				end
			end
			else if (m_cnt != AM_PERIOD-1)
			begin
				m_cnt++;
			end
			else
			begin
				at    = 1'b1;   // expected marker position
				m_cnt = 0;
				if (hit[m_lane])
				begin
					chk    = 1'b1;
					m_bad  = 0;
					m_good = (m_good < 7) ? m_good + 1 : 7;
					if (m_state == ST_ACQUIRE && m_good >= thr_lock)
					begin
						m_state  = ST_LOCKED;
						exp_lock = 1'b1;
					end
				end
				else if (m_state == ST_ACQUIRE)
				begin
					m_state    = ST_SEARCH;
					exp_resync = 1'b1;
				end
				else
				begin
					m_bad++;
					if (m_bad >= thr_unlock)
					begin
						m_state    = ST_SEARCH;
						m_bad      = 0;
						exp_lock   = 1'b0;
						exp_resync = 1'b1;
					end
				end
			end
			if (chk && p[39:32] != m_acc && exp_err != '1)
			begin
				exp_err = exp_err + 16'd1;
			end
			m_acc    = at ? 8'h00 : m_acc ^ interleaved_parity(p);
			exp_data = chk ? {CTRL_SH, BLOCK_TYPE_CTRL, 56'd0} : blk;
			exp_sol  = chk;
			if (chk)
			begin
				exp_lane = m_lane;
			end
		end
	endtask

	// entered just after a rising edge and returns at the next one
	task automatic drive_cycle(input logic v, input logic en, input logic [65:0] blk);
		valid     <= v;
		rf_enable <= en;
		data      <= blk;
		@(negedge clock);
		check_outputs();   // block sampled on the previous edge
		if (o_resync)
		begin
			resync_seen++;
		end
		predict(v, en, blk);
		@(posedge clock);
	endtask

	task automatic send_block(input logic [65:0] blk);
		drive_cycle(1'b1, 1'b1, blk);
		repeat ($urandom % 3)
		begin
			drive_cycle(1'b0, 1'b1, 66'd0);   // idle gap
		end
	endtask

	task automatic run_test(input int t);
		test_t       tc;
		logic [63:0] p;
		logic [7:0]  bip;
		logic [47:0] pat;
		logic [15:0] err_start;
		logic [15:0] delta;
		tc           = tests[t];
		cur_name     = names[t];
		valid_thr    <= tc.val_thr;
		invalid_thr  <= tc.inv_thr;
		compare_mask <= tc.mask;
		drive_cycle(1'b0, 1'b0, 66'd0);   // FSM back to search
		drive_cycle(1'b0, 1'b0, 66'd0);
		err_start   = exp_err;
		resync_seen = 0;
		pat         = AM_TABLE[tc.lane];
		for (int k = 0; k < int'(tc.periods); k++)
		begin
			bip = 8'h00;
			for (int b = 0; b < AM_PERIOD-1; b++)
			begin
				p   = {$urandom, $urandom};
				bip ^= interleaved_parity(p);
				send_block({2'b01, p});
			end
			p = {pat[47:24], bip, pat[23:0], ~bip};   // bip7 as inverse of bip3
			if (k >= int'(tc.first_fault) && k < int'(tc.first_fault) + int'(tc.n_fault))
			begin
				case (tc.fault)
					F_BAD_MK:    p[63]    = ~p[63];
					F_BAD_BIP:   p[32]    = ~p[32];
					F_MASK_FLIP: p[15:8]  = ~p[15:8];   // low byte of M6
					default:     p[63:0]  = p[63:0];
				endcase
			end
			send_block({CTRL_SH, p});
		end
		drive_cycle(1'b0, 1'b1, 66'd0);   // flush last block's check
		@(negedge clock);
		delta = o_error_counter - err_start;
		check_value("final lock", 66'(tc.exp_lock), 66'(o_am_lock));
		check_value("final lane id", 66'(tc.exp_lane), 66'(o_lane_id));
		check_value("bip3 errors", 66'(tc.exp_err), 66'(delta));
		if (tc.exp_resync != 2'd0 && resync_seen == 0)
		begin
			report_failure("expected resync pulse never arrived");
		end
		else
		begin
			check_value("resync pulses", 66'(tc.exp_resync), 66'(resync_seen));
		end
		@(posedge clock);
	endtask

	initial
	begin
		void'($urandom(97841));   // one seed for the whole run
		n_tests      = 0;
		rf_enable    = 1'b0;
		valid        = 1'b0;
		block_lock   = 1'b1;
		data         = 66'd0;
		valid_thr    = 3'd0;
		invalid_thr  = 3'd0;
		compare_mask = 48'd0;
		m_state      = ST_SEARCH;
		m_cnt        = 0;
		m_good       = 0;
		m_bad        = 0;
		m_lane       = 2'd0;
		m_acc        = 8'h00;
		exp_data     = 66'd0;
		exp_valid    = 1'b0;
		exp_sol      = 1'b0;
		exp_resync   = 1'b0;
		exp_lock     = 1'b0;
		exp_lane     = 2'd0;
		exp_err      = 16'd0;
		//       name               lane val inv mask             per fault        1st n lk ln er rs
		add_test("lock_lane0",      0,   3,  2,  48'hFFFFFFFFFFFF, 4, F_GOOD,      0, 0, 1, 0, 0, 0);
		add_test("lock_lane1",      1,   1,  2,  48'hFFFFFFFFFFFF, 3, F_GOOD,      0, 0, 1, 1, 0, 0);
		add_test("lock_lane2",      2,   0,  2,  48'hFFFFFFFFFFFF, 3, F_GOOD,      0, 0, 1, 2, 0, 0);
		add_test("lock_lane3",      3,   5,  2,  48'hFFFFFFFFFFFF, 6, F_GOOD,      0, 0, 1, 3, 0, 0);
		add_test("bip_errors",      2,   2,  3,  48'hFFFFFFFFFFFF, 6, F_BAD_BIP,   2, 3, 1, 2, 3, 0);
		add_test("bad_below_thr",   1,   2,  3,  48'hFFFFFFFFFFFF, 7, F_BAD_MK,    2, 2, 1, 1, 0, 0);
		add_test("bad_drop_relock", 3,   2,  2,  48'hFFFFFFFFFFFF, 8, F_BAD_MK,    2, 2, 1, 3, 0, 1);
		add_test("mask_flip_part",  0,   2,  2,  48'hFFFFFFFFFF00, 3, F_MASK_FLIP, 0, 3, 1, 0, 0, 0);
		add_test("mask_flip_full",  0,   2,  2,  48'hFFFFFFFFFFFF, 3, F_MASK_FLIP, 0, 3, 0, 0, 0, 0);
		@(posedge clock);
		while (reset)
		begin
			@(posedge clock);
		end
		@(negedge clock);
		cur_name = "after_reset";
		check_outputs();   // every output zero before any block
		@(posedge clock);
		for (int t = 0; t < n_tests; t++)
		begin
			run_test(t);
		end
		@(negedge clock);
		$display("ALL TESTS PASSED");
		$finish;
	end

	// limit in 100 ns cycles with 4 per block against at most 3 used
	initial
	begin
		int limit;
		#1;
		limit = 400;
		for (int t = 0; t < n_tests; t++)
		begin
			limit += (int'(tests[t].periods) * AM_PERIOD + 8) * 4;
		end
		repeat (limit)
		begin
			@(posedge clock);
		end
		report_failure("run exceeded the watchdog limit");
	end

endmodule

// File: tests/tb_clock_gen.sv
/*
  testbench clock and reset source
  100 ns clock, reset held for 8 rising edges
*/

`timescale 1ns/1ns

module tb_clock_gen
(
	output logic o_clock,
	output logic o_reset
);

	initial
	begin
		o_clock = 1'b0;
		forever
		begin
			#50 o_clock = ~o_clock;   // half period
		end
	end

	initial
	begin
		o_reset = 1'b1;
		repeat (8)
		begin
			@(posedge o_clock);
		end
		o_reset <= 1'b0;   // released on the 8th edge
	end

endmodule
